// ==== vlog.f ====
+incdir+logic
+incdir+testbench
logic/rv_isa_pkg.sv
logic/dp_ctrl_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/imm_extend.sv
logic/datapath_multicycle.sv
logic/control_fsm.sv
logic/cpu_top.sv
testbench/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_cpu_top
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_rv_model.svh ====
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

localparam logic [6:0]  opc_load   = 7'b0000011;
localparam logic [6:0]  opc_store  = 7'b0100011;
localparam logic [6:0]  opc_op     = 7'b0110011;
localparam logic [6:0]  opc_op_imm = 7'b0010011;
localparam logic [6:0]  opc_branch = 7'b1100011;
localparam logic [6:0]  opc_jal    = 7'b1101111;
localparam logic [6:0]  opc_lui    = 7'b0110111;  // Outside the supported set
localparam logic [31:0] data_base  = 32'h400;     // Held in x8
localparam logic [31:0] store_base = 32'h600;     // Held in x9
localparam logic [31:0] end_marker = 32'h0000006f;  // jal x0, 0

logic [31:0] lfsr_state = 32'd92930;
logic [31:0] image [1024];
int          wp;
int          soff;
string       slot_tag [64];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];

// Galois LFSR, one step per bit
function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val        = {val[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
endfunction

function automatic logic [4:0] pick_reg();
    return 5'(1 + take_bits(3) % 7);  // x1 to x7
endfunction

function automatic logic [2:0] alu_funct3(int sel);
    case (sel)
        2:       return 3'b111;
        3:       return 3'b110;
        4:       return 3'b100;
        5:       return 3'b010;
        default: return 3'b000;  // add and sub
    endcase
endfunction

function automatic logic [2:0] branch_funct3(int sel);
    case (sel)
        1:       return 3'b001;
        2:       return 3'b100;
        default: return 3'b000;
    endcase
endfunction

function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
endfunction

function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] b_word(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] j_word(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

function automatic void emit(logic [31:0] word);
    image[wp] = word;
    wp++;
endfunction

// Stores into the result area walk up one word at a time
function automatic void emit_store(logic [4:0] rs2, string tag);
    emit(s_word(12'(soff), rs2, 5'd9));
    slot_tag[soff / 4] = tag;
    soff += 4;
endfunction

function automatic string test_name(logic [31:0] addr);
    if (addr >= store_base && addr < store_base + 256) begin
        return slot_tag[(addr - store_base) >> 2];
    end
    return "completion";
endfunction

function automatic void gen_program();
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    int         sel;
    int         va;
    int         vb;
    for (int i = 0; i < 1024; i++) begin
        image[i] = 32'(i) * 32'h9e37_79b9 + 32'h5a5a_1234;
    end
    wp   = 0;
    soff = 0;
    emit(i_word(12'(data_base), 5'd0, 3'b000, 5'd8, opc_op_imm));
    emit(i_word(12'(store_base), 5'd0, 3'b000, 5'd9, opc_op_imm));
    for (int r = 1; r <= 7; r++) begin
        emit(i_word(12'(take_bits(12)), 5'd0, 3'b000, 5'(r), opc_op_imm));
    end
    for (int i = 0; i < 40; i++) begin
        sel = int'(take_bits(3) % 6);
        f3  = alu_funct3(sel);
        rd  = pick_reg();
        rs1 = pick_reg();
        if (take_bits(1) == 32'd1) begin
            rs2 = pick_reg();
            emit(r_word((sel == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
        end else begin
            emit(i_word(12'(take_bits(12)), rs1, f3, rd, opc_op_imm));  // sub becomes addi
        end
    end
    for (int r = 1; r <= 7; r++) begin
        emit_store(5'(r), "arith");
    end
    for (int i = 0; i < 4; i++) begin
        rd = pick_reg();
        emit(i_word(12'(take_bits(4) * 4), 5'd8, 3'b010, rd, opc_load));
        emit(i_word(12'(take_bits(12)), rd, 3'b000, rd, opc_op_imm));
        emit_store(rd, "load");
    end
    emit(i_word(12'(take_bits(4) * 4), 5'd8, 3'b010, 5'd0, opc_load));
    emit_store(5'd0, "load");
    // Small operands so that equal pairs turn up
    for (int i = 0; i < 9; i++) begin
        va = int'(take_bits(2)) - 2;
        vb = int'(take_bits(2)) - 2;
        emit(i_word(12'(va), 5'd0, 3'b000, 5'd1, opc_op_imm));
        emit(i_word(12'(vb), 5'd0, 3'b000, 5'd2, opc_op_imm));
        emit(b_word(13'd8, 5'd2, 5'd1, branch_funct3(i % 3)));
        emit_store(5'd1, "branch");
    end
    for (int j = 1; j <= 2; j++) begin
        emit(j_word(21'(4 + 4 * j), 5'(4 + j)));
        for (int k = 0; k < j; k++) begin
            emit_store(5'd1, "jump");  // Jumped over
        end
        emit_store(5'(4 + j), "jump");
    end
    emit(i_word(12'd2046, 5'd0, 3'b000, 5'd10, opc_op_imm));
    emit(i_word(12'd2046, 5'd10, 3'b000, 5'd10, opc_op_imm));
    emit(s_word(12'd0, 5'd7, 5'd10));  // Last word of memory
    emit(end_marker);
endfunction

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b110:  return a | b;
        3'b111:  return a & b;
        default: return 32'd0;
    endcase
endfunction

// ISA model over a copy of the image; returns the store count or -1
function automatic int run_reference();
    logic [31:0] xr [32];
    logic [31:0] dm [1024];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        wr;
    logic        taken;
    int          steps;
    int          result;
    for (int i = 0; i < 32; i++) begin
        xr[i] = '0;
    end
    dm     = image;
    pc     = `RV_RESET_PC;
    steps  = 0;
    result = -1;
    while (result == -1 && steps < 4000) begin
        ins   = dm[pc[11:2]];
        a     = xr[ins[19:15]];
        b     = xr[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = pc + 32'd4;
        wr      = 1'b0;
        res     = '0;
        taken   = 1'b0;
        case (ins[6:0])
            opc_op: begin
                res = alu_ref(ins[14:12], ins[30], a, b);
                wr  = 1'b1;
            end
            opc_op_imm: begin
                res = alu_ref(ins[14:12], 1'b0, a, imm_i);
                wr  = 1'b1;
            end
            opc_load: begin
                ea  = a + imm_i;
                res = dm[ea[11:2]];
                wr  = 1'b1;
            end
            opc_store: begin
                ea           = a + imm_s;
                dm[ea[11:2]] = b;
                exp_addr.push_back(ea);
                exp_data.push_back(b);
            end
            opc_branch: begin
                case (ins[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            opc_jal: begin
                res     = pc + 32'd4;
                wr      = 1'b1;
                next_pc = pc + imm_j;
            end
            default: begin
                steps = 4000;  // Stray opcode, give up
            end
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            xr[ins[11:7]] = res;
        end
        pc = next_pc;
        steps++;
        if (dm[pc[11:2]] == end_marker) begin
            result = exp_addr.size();
        end
    end
    return result;
endfunction

`endif

// ==== testbench/tb_cpu_top.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_cpu_top;
    logic                clk;
    logic                reset;
    logic [`RV_XLEN-1:0] m_rd;
    logic [`RV_XLEN-1:0] m_addr;
    logic [`RV_XLEN-1:0] m_wd;
    logic                m_we;
    logic                fault;

    logic [31:0] mem [1024];
    int          n_expected;
    int          stores_seen;
    int          value_errors;
    int          other_errors;
    logic        fault_phase;

    `include "tb_rv_model.svh"

    cpu_top u_cpu_top (
        .clk    (clk),
        .reset  (reset),
        .m_rd   (m_rd),
        .m_addr (m_addr),
        .m_wd   (m_wd),
        .m_we   (m_we),
        .fault  (fault)
    );

    always #4 clk = ~clk;

    // Image reloads for as long as reset is high
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= image[i];
            end
        end else if (m_we) begin
            mem[m_addr[11:2]] <= m_wd;
        end
    end

    assign m_rd = reset ? '0 : mem[m_addr[11:2]];

    task automatic check_store();
        string name;
        assert (stores_seen < n_expected) else begin
            other_errors++;
            $display("unexpected store of %h to address %h after all %0d expected stores",
                     m_wd, m_addr, n_expected);
        end
        if (stores_seen < n_expected) begin
            name = test_name(exp_addr[stores_seen]);
            assert (m_addr == exp_addr[stores_seen]) else begin
                value_errors++;
                $display("error %s store %0d address: expected %h, actual %h",
                         name, stores_seen, exp_addr[stores_seen], m_addr);
            end
            assert (m_wd == exp_data[stores_seen]) else begin
                value_errors++;
                $display("error %s store %0d data: expected %h, actual %h",
                         name, stores_seen, exp_data[stores_seen], m_wd);
            end
        end
        stores_seen++;
    endtask

    // Store monitor samples mid-cycle when the memory port has settled
    always @(negedge clk) begin
        if (!reset && !fault_phase) begin
            assert (!fault) else begin
                other_errors++;
                $display("fault went high while the program was running at %0t", $time);
            end
            if (m_we) begin
                check_store();
            end
        end
    end

    initial begin
        int cyc;
        clk          = 1'b0;
        reset        = 1'b1;
        fault_phase  = 1'b0;
        stores_seen  = 0;
        value_errors = 0;
        other_errors = 0;
        gen_program();
        n_expected = run_reference();
        assert (n_expected >= 0) else begin
            other_errors++;
            $display("reference model never reached the end of the program");
        end
        if (n_expected < 0) begin
            n_expected = 0;
        end
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;

        cyc = 0;
        while (stores_seen < n_expected && cyc < 4000) begin
            @(posedge clk);
            cyc++;
        end
        assert (stores_seen >= n_expected) else begin
            other_errors++;
            $display("timed out after %0d cycles with %0d of %0d stores seen",
                     cyc, stores_seen, n_expected);
        end
        repeat (40) @(negedge clk);  // Spinning on the final jal
        assert (stores_seen == n_expected) else begin
            value_errors++;
            $display("error completion store count: expected %0d, actual %0d",
                     n_expected, stores_seen);
        end

        // Second run starts from a lui word
        fault_phase = 1'b1;
        image[0]    = {20'h12345, 5'd1, opc_lui};
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        cyc = 0;
        while (!fault && cyc < 10) begin
            @(negedge clk);
            cyc++;
        end
        assert (fault) else begin
            other_errors++;
            $display("fault did not rise within 10 cycles of the unsupported opcode");
        end
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            assert (!m_we) else begin
                other_errors++;
                $display("memory write seen in the fault state at %0t", $time);
            end
            assert (fault) else begin
                other_errors++;
                $display("fault dropped without a reset at %0t", $time);
            end
        end

        $display("stores %0d of %0d, value errors %0d, other errors %0d",
                 stores_seen, n_expected, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module cpu_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [`RV_XLEN-1:0] m_rd,
    output logic [`RV_XLEN-1:0] m_addr,
    output logic [`RV_XLEN-1:0] m_wd,
    output logic                m_we,
    output logic                fault
);
    dp_ctrl_pkg::dp_ctrl_t  ctrl;
    rv_isa_pkg::alu_flags_t flags;
    logic [31:0]            instr;

    control_fsm u_control_fsm (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl),
        .m_we  (m_we),
        .fault (fault)
    );

    datapath_multicycle u_datapath (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .m_rd   (m_rd),
        .m_addr (m_addr),
        .m_wd   (m_wd),
        .instr  (instr),
        .flags  (flags)
    );

endmodule

// ==== logic/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            instr,
    input  rv_isa_pkg::alu_flags_t flags,
    output dp_ctrl_pkg::dp_ctrl_t  ctrl,
    output logic                   m_we,
    output logic                   fault
);
    dp_ctrl_pkg::ctrl_state_e state;
    dp_ctrl_pkg::ctrl_state_e state_next;
    rv_isa_pkg::opcode_e      opcode;
    logic [2:0]               funct3;
    logic                     alt_funct7;
    rv_isa_pkg::imm_src_e     imm_src_dec;
    rv_isa_pkg::alu_op_e      alu_op_dec;
    logic                     branch_taken;

    assign opcode     = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign alt_funct7 = (instr[31:25] == rv_isa_pkg::f7_alt);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dp_ctrl_pkg::st_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::opc_store:  imm_src_dec = rv_isa_pkg::imm_s;
            rv_isa_pkg::opc_branch: imm_src_dec = rv_isa_pkg::imm_b;
            rv_isa_pkg::opc_jal:    imm_src_dec = rv_isa_pkg::imm_j;
            default:                imm_src_dec = rv_isa_pkg::imm_i;
        endcase
    end

    // Only R-type distinguishes sub from add
    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_add_sub:
                alu_op_dec = (opcode == rv_isa_pkg::opc_op && alt_funct7) ?
                             rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
            rv_isa_pkg::f3_slt: alu_op_dec = rv_isa_pkg::alu_slt;
            rv_isa_pkg::f3_xor: alu_op_dec = rv_isa_pkg::alu_xor;
            rv_isa_pkg::f3_or:  alu_op_dec = rv_isa_pkg::alu_or;
            rv_isa_pkg::f3_and: alu_op_dec = rv_isa_pkg::alu_and;
            default:            alu_op_dec = rv_isa_pkg::alu_add;
        endcase
    end

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_beq: branch_taken = flags.zero;
            rv_isa_pkg::f3_bne: branch_taken = !flags.zero;
            rv_isa_pkg::f3_blt: branch_taken = flags.negative ^ flags.overflow;
            default:            branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl           = '0;  // All enables off
        ctrl.imm_src   = imm_src_dec;
        ctrl.alu_ctrl  = rv_isa_pkg::alu_add;
        ctrl.alu_src_a = dp_ctrl_pkg::alu_src_reg_1;
        ctrl.alu_src_b = dp_ctrl_pkg::alu_src_reg_2;
        ctrl.res_src   = dp_ctrl_pkg::res_src_alu_out;
        m_we           = 1'b0;
        state_next     = state;
        case (state)
            dp_ctrl_pkg::st_fetch: begin
                ctrl.en_ir     = 1'b1;
                ctrl.alu_src_a = dp_ctrl_pkg::alu_src_pc;
                ctrl.alu_src_b = dp_ctrl_pkg::alu_src_4;
                state_next     = dp_ctrl_pkg::st_decode;
            end
            dp_ctrl_pkg::st_decode: begin
                // pc takes pc + 4 while the ALU forms the jump target
                ctrl.en_npc_r  = 1'b1;
                ctrl.alu_src_a = dp_ctrl_pkg::alu_src_pc;
                ctrl.alu_src_b = dp_ctrl_pkg::alu_src_ext_imm;
                case (opcode)
                    rv_isa_pkg::opc_load,
                    rv_isa_pkg::opc_store:  state_next = dp_ctrl_pkg::st_mem_addr;
                    rv_isa_pkg::opc_op:     state_next = dp_ctrl_pkg::st_execute_r;
                    rv_isa_pkg::opc_op_imm: state_next = dp_ctrl_pkg::st_execute_i;
                    rv_isa_pkg::opc_branch: state_next = dp_ctrl_pkg::st_branch;
                    rv_isa_pkg::opc_jal:    state_next = dp_ctrl_pkg::st_jal;
                    default:                state_next = dp_ctrl_pkg::st_fault;
                endcase
            end
            dp_ctrl_pkg::st_mem_addr: begin
                ctrl.alu_src_b = dp_ctrl_pkg::alu_src_ext_imm;
                state_next     = (opcode == rv_isa_pkg::opc_load) ?
                                 dp_ctrl_pkg::st_mem_read : dp_ctrl_pkg::st_mem_write;
            end
            dp_ctrl_pkg::st_mem_read: begin
                ctrl.addr_src = 1'b1;
                state_next    = dp_ctrl_pkg::st_mem_wb;
            end
            dp_ctrl_pkg::st_mem_wb: begin
                ctrl.rf_we   = 1'b1;
                ctrl.res_src = dp_ctrl_pkg::res_src_mem;
                state_next   = dp_ctrl_pkg::st_fetch;
            end
            dp_ctrl_pkg::st_mem_write: begin
                ctrl.addr_src = 1'b1;
                m_we          = 1'b1;
                state_next    = dp_ctrl_pkg::st_fetch;
            end
            dp_ctrl_pkg::st_execute_r: begin
                ctrl.alu_ctrl = alu_op_dec;
                state_next    = dp_ctrl_pkg::st_alu_wb;
            end
            dp_ctrl_pkg::st_execute_i: begin
                ctrl.alu_ctrl  = alu_op_dec;
                ctrl.alu_src_b = dp_ctrl_pkg::alu_src_ext_imm;
                state_next     = dp_ctrl_pkg::st_alu_wb;
            end
            dp_ctrl_pkg::st_alu_wb: begin
                ctrl.rf_we = 1'b1;
                state_next = dp_ctrl_pkg::st_fetch;
            end
            dp_ctrl_pkg::st_branch: begin
                ctrl.alu_ctrl = rv_isa_pkg::alu_sub;
                ctrl.en_npc_r = branch_taken;  // Target still in ALU-out
                state_next    = dp_ctrl_pkg::st_fetch;
            end
            dp_ctrl_pkg::st_jal: begin
                ctrl.rf_we     = 1'b1;
                ctrl.rf_wd_src = 1'b1;
                ctrl.en_npc_r  = 1'b1;
                state_next     = dp_ctrl_pkg::st_fetch;
            end
            default: begin
                state_next = dp_ctrl_pkg::st_fault;  // Sticky until reset
            end
        endcase
    end

    assign fault = (state == dp_ctrl_pkg::st_fault);

endmodule

// ==== logic/datapath_multicycle.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module datapath_multicycle (
    input  logic                   clk,
    input  logic                   reset,
    input  dp_ctrl_pkg::dp_ctrl_t  ctrl,
    input  logic [`RV_XLEN-1:0]    m_rd,
    output logic [`RV_XLEN-1:0]    m_addr,
    output logic [`RV_XLEN-1:0]    m_wd,
    output logic [31:0]            instr,
    output rv_isa_pkg::alu_flags_t flags
);
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] m_rd_r;
    logic [`RV_XLEN-1:0] rd1_r;
    logic [`RV_XLEN-1:0] rd2_r;
    logic [`RV_XLEN-1:0] alu_out_r;

    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] reg_rd1;
    logic [`RV_XLEN-1:0] reg_rd2;
    logic [`RV_XLEN-1:0] reg_wd;
    logic [`RV_XLEN-1:0] ext_imm;
    logic [`RV_XLEN-1:0] src_a;
    logic [`RV_XLEN-1:0] src_b;
    logic [`RV_XLEN-1:0] alu_y;

    // Architectural and staging registers
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= `RV_XLEN'(`RV_RESET_PC);
            instr     <= '0;
            m_rd_r    <= '0;
            rd1_r     <= '0;
            rd2_r     <= '0;
            alu_out_r <= '0;
        end else begin
            if (ctrl.en_npc_r) begin
                pc <= result;
            end
            if (ctrl.en_ir) begin
                instr <= m_rd;
            end
            m_rd_r    <= m_rd;
            rd1_r     <= reg_rd1;
            rd2_r     <= reg_rd2;
            alu_out_r <= alu_y;
        end
    end

    assign result = (ctrl.res_src == dp_ctrl_pkg::res_src_mem) ? m_rd_r : alu_out_r;
    assign m_addr = ctrl.addr_src ? result : pc;
    assign m_wd   = rd2_r;
    assign reg_wd = ctrl.rf_wd_src ? pc : result;  // pc already holds the link address

    regfile u_regfile (
        .clk (clk),
        .ra1 (instr[19:15]),
        .ra2 (instr[24:20]),
        .wa  (instr[11:7]),
        .wd  (reg_wd),
        .we  (ctrl.rf_we),
        .rd1 (reg_rd1),
        .rd2 (reg_rd2)
    );

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm     (ext_imm)
    );

    always_comb begin
        case (ctrl.alu_src_a)
            dp_ctrl_pkg::alu_src_reg_2:   src_a = rd2_r;
            dp_ctrl_pkg::alu_src_ext_imm: src_a = ext_imm;
            dp_ctrl_pkg::alu_src_pc:      src_a = pc;
            dp_ctrl_pkg::alu_src_4:       src_a = `RV_XLEN'(4);
            default:                      src_a = rd1_r;
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_b)
            dp_ctrl_pkg::alu_src_reg_1:   src_b = rd1_r;
            dp_ctrl_pkg::alu_src_ext_imm: src_b = ext_imm;
            dp_ctrl_pkg::alu_src_pc:      src_b = pc;
            dp_ctrl_pkg::alu_src_4:       src_b = `RV_XLEN'(4);
            default:                      src_b = rd2_r;
        endcase
    end

    alu u_alu (
        .a     (src_a),
        .b     (src_b),
        .op    (ctrl.alu_ctrl),
        .y     (alu_y),
        .flags (flags)
    );

endmodule

// ==== logic/imm_extend.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module imm_extend (
    input  logic [31:0]          instr,
    input  rv_isa_pkg::imm_src_e imm_src,
    output logic [`RV_XLEN-1:0]  imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            rv_isa_pkg::imm_s:
                imm = {{(`RV_XLEN-12){sign}}, instr[31:25], instr[11:7]};
            // Branch offset, bit 0 implied
            rv_isa_pkg::imm_b:
                imm = {{(`RV_XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_isa_pkg::imm_j:
                imm = {{(`RV_XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = {{(`RV_XLEN-12){sign}}, instr[31:20]};  // I format
        endcase
    end

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module regfile (
    input  logic                clk,
    input  logic [4:0]          ra1,
    input  logic [4:0]          ra2,
    input  logic [4:0]          wa,
    input  logic [`RV_XLEN-1:0] wd,
    input  logic                we,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);
    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin  // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module alu (
    input  logic [`RV_XLEN-1:0]     a,
    input  logic [`RV_XLEN-1:0]     b,
    input  rv_isa_pkg::alu_op_e     op,
    output logic [`RV_XLEN-1:0]     y,
    output rv_isa_pkg::alu_flags_t  flags
);
    localparam int msb = `RV_XLEN - 1;

    logic                is_sub;
    logic [`RV_XLEN-1:0] b_eff;
    logic [`RV_XLEN:0]   sum;       // Top bit is carry out
    logic                overflow;

    // slt shares the subtractor
    assign is_sub   = (op == rv_isa_pkg::alu_sub) || (op == rv_isa_pkg::alu_slt);
    assign b_eff    = is_sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, is_sub};
    assign overflow = (a[msb] == b_eff[msb]) && (sum[msb] != a[msb]);

    always_comb begin
        case (op)
            rv_isa_pkg::alu_and: y = a & b;
            rv_isa_pkg::alu_or:  y = a | b;
            rv_isa_pkg::alu_xor: y = a ^ b;
            rv_isa_pkg::alu_slt: y = {{msb{1'b0}}, sum[msb] ^ overflow};
            default:             y = sum[msb:0];  // add and sub
        endcase
    end

    assign flags.zero     = (y == '0);
    assign flags.negative = y[msb];
    assign flags.carry    = sum[`RV_XLEN];
    assign flags.overflow = overflow;

endmodule

// ==== logic/dp_ctrl_pkg.sv ====
package dp_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_src_reg_1,
        alu_src_reg_2,
        alu_src_ext_imm,
        alu_src_pc,
        alu_src_4
    } alu_src_e;

    typedef enum logic {
        res_src_alu_out,
        res_src_mem
    } res_src_e;

    // Everything the datapath needs for one cycle
    typedef struct packed {
        logic                 rf_we;
        rv_isa_pkg::imm_src_e imm_src;
        rv_isa_pkg::alu_op_e  alu_ctrl;
        alu_src_e             alu_src_a;
        alu_src_e             alu_src_b;
        res_src_e             res_src;
        logic                 addr_src;   // 1 selects result as memory address
        logic                 en_ir;
        logic                 en_npc_r;
        logic                 rf_wd_src;  // 1 writes pc into rd
    } dp_ctrl_t;

    typedef enum logic [3:0] {
        st_fetch,
        st_decode,
        st_mem_addr,
        st_mem_read,
        st_mem_wb,
        st_mem_write,
        st_execute_r,
        st_execute_i,
        st_alu_wb,
        st_branch,
        st_jal,
        st_fault
    } ctrl_state_e;

endpackage

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    // ALU funct3 codes, shared by op and op_imm
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch funct3 codes
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;

    localparam logic [6:0] f7_alt = 7'b0100000;  // sub in R-type

    typedef enum logic [1:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_j
    } imm_src_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_t;

endpackage

// ==== logic/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data path and register width
`define RV_XLEN 32

// Architectural integer registers
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 0

`endif
